// ==== Makefile ====
TB_TOP := branch_predictor_tb
RTL_TOP := branch_predictor
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(RTL_TOP)
	verilator --lint-only --timing -f build.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
verilog/bht_pkg.sv
verilog/branch_pkg.sv
verilog/bht_table.sv
verilog/branch_resolver.sv
verilog/fetch_pc_gen.sv
verilog/branch_predictor.sv
dv/branch_predictor_tb.sv

// ==== dv/branch_predictor_tb.sv ====
`timescale 1ns/100ps

module branch_predictor_tb;
	import bht_pkg::*;
	import branch_pkg::*;

	localparam int MAX_ROWS = 64;
	localparam logic [BTYPE_W-1:0] BEQ = BTYPE_W'(1 << BT_BEQ);
	localparam logic [BTYPE_W-1:0] BNE = BTYPE_W'(1 << BT_BNE);
	localparam logic [BTYPE_W-1:0] BLT = BTYPE_W'(1 << BT_BLT);
	localparam logic [BTYPE_W-1:0] BGE = BTYPE_W'(1 << BT_BGE);
	localparam logic [BTYPE_W-1:0] BLTU = BTYPE_W'(1 << BT_BLTU);
	localparam logic [BTYPE_W-1:0] BGEU = BTYPE_W'(1 << BT_BGEU);

	// one cycle of stimulus and the outputs expected before the next edge
	typedef struct packed {
		logic [PC_W-1:0] id_pc;
		logic [PC_W-1:0] id_target;
		logic id_is_jump;
		logic id_is_btype;
		logic [PC_W-1:0] exe_pc;
		logic [BTYPE_W-1:0] exe_btype;
		logic exe_z;
		logic exe_less;
		logic isr_running;
		logic stall;
		logic [PC_W-1:0] x_if_pc;
		logic x_pred;
		logic [PC_W-1:0] x_pbt;
		logic [CORR_W-1:0] x_corr;
		logic [PC_W-1:0] x_exe_pbt;
		logic x_flush;
		logic x_jib;
	} row_t;

	logic CLK, nrst, en, stall, isr_running;
	logic [PC_W-1:0] id_pc, id_target, exe_pc;
	logic id_is_jump, id_is_btype, exe_z, exe_less;
	logic [BTYPE_W-1:0] exe_btype;
	logic [PC_W-1:0] if_pc, if_pbt, exe_pbt, exe_cni;
	logic if_prediction, flush, id_jump_in_bht;
	logic [CORR_W-1:0] exe_correction;

	row_t rows [MAX_ROWS];
	int n_rows;
	int cur_row;
	// branch at 6, jump at 9, four more branches in set 6
	logic [PC_W-1:0] tb_br, tb_jmp;
	logic [PC_W-1:0] tf [4];

	branch_predictor DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// targets sit high in memory where no entry lives
	function automatic logic [PC_W-1:0] random_target();
		return PC_W'(32'h200 + ($urandom % 32'hF0));
	endfunction

	task automatic in_row(input logic [PC_W-1:0] ipc, input logic [PC_W-1:0] itgt,
			input logic ijmp, input logic ibr, input logic [PC_W-1:0] epc,
			input logic [BTYPE_W-1:0] ebt, input logic ez, input logic el,
			input logic isr, input logic stl);
		rows[n_rows].id_pc = ipc;
		rows[n_rows].id_target = itgt;
		rows[n_rows].id_is_jump = ijmp;
		rows[n_rows].id_is_btype = ibr;
		rows[n_rows].exe_pc = epc;
		rows[n_rows].exe_btype = ebt;
		rows[n_rows].exe_z = ez;
		rows[n_rows].exe_less = el;
		rows[n_rows].isr_running = isr;
		rows[n_rows].stall = stl;
	endtask

	task automatic out_row(input logic [PC_W-1:0] xpc, input logic xpred,
			input logic [PC_W-1:0] xpbt, input logic [CORR_W-1:0] xcorr,
			input logic [PC_W-1:0] xepbt, input logic xflush, input logic xjib);
		rows[n_rows].x_if_pc = xpc;
		rows[n_rows].x_pred = xpred;
		rows[n_rows].x_pbt = xpbt;
		rows[n_rows].x_corr = xcorr;
		rows[n_rows].x_exe_pbt = xepbt;
		rows[n_rows].x_flush = xflush;
		rows[n_rows].x_jib = xjib;
		n_rows++;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: row %0d %s = 0x%0h, expected 0x%0h", cur_row, name, got, exp);
			$display("Something failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic build_rows();
		n_rows = 0;
		////////////////////////////////////////////////////////////////////
		// reset state, counting, stall
		////////////////////////////////////////////////////////////////////
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(0, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		out_row(1, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(1, 0, 0, CORR_NONE, 0, 0, 0);
		// insert branch at 6 and jump at 9, the new jump flushes once
		in_row(6, tb_br, 0, 1, 0, 0, 0, 0, 0, 0);
		out_row(2, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(9, tb_jmp, 1, 0, 0, 0, 0, 0, 0, 0);
		out_row(3, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(4, 0, 0, CORR_NONE, 0, 1, 0);
		// known jump, no flush
		in_row(9, tb_jmp, 1, 0, 0, 0, 0, 0, 0, 0);
		out_row(5, 0, 0, CORR_NONE, 0, 0, 1);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(6, 0, tb_br, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(7, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(8, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(9, 1, tb_jmp, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(tb_jmp, 0, 0, CORR_NONE, 0, 0, 0);
		////////////////////////////////////////////////////////////////////
		// conditions, corrections and counter training on the branch at 6
		////////////////////////////////////////////////////////////////////
		// counter 1 -> 2
		in_row(0, 0, 0, 0, 6, BEQ, 1, 0, 0, 0);
		out_row(tb_jmp + 1, 0, 0, CORR_PBT, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(tb_br, 0, 0, CORR_NONE, 0, 1, 0);
		// counter 2 -> 1
		in_row(0, 0, 0, 0, 6, BNE, 1, 0, 0, 0);
		out_row(tb_br + 1, 0, 0, CORR_CNI, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		out_row(7, 0, 0, CORR_NONE, 0, 1, 0);
		// not taken walks down to 0 and stays
		in_row(0, 0, 0, 0, 6, BLT, 0, 0, 0, 0);
		out_row(8, 0, 0, CORR_NONE, tb_br, 0, 0);
		in_row(0, 0, 0, 0, 6, BGE, 0, 1, 0, 0);
		out_row(9, 1, tb_jmp, CORR_NONE, tb_br, 0, 0);
		// two taken resolutions reach predicted taken
		in_row(0, 0, 0, 0, 6, BLTU, 0, 1, 0, 0);
		out_row(tb_jmp, 0, 0, CORR_PBT, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 6, BGEU, 0, 0, 0, 0);
		out_row(tb_br, 0, 0, CORR_PBT, tb_br, 1, 0);
		// second mispredict in a row still flushes the following cycle
		in_row(0, 0, 0, 0, 6, BNE, 0, 0, 0, 0);
		out_row(tb_br, 0, 0, CORR_NONE, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 6, BEQ, 0, 0, 0, 0);
		out_row(tb_br + 1, 0, 0, CORR_CNI, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 6, BGE, 0, 0, 0, 0);
		out_row(7, 0, 0, CORR_NONE, tb_br, 1, 0);
		// saturates at 3
		in_row(0, 0, 0, 0, 6, BLT, 0, 1, 0, 0);
		out_row(8, 0, 0, CORR_NONE, tb_br, 0, 0);
		// back down 3 -> 2 -> 1 -> 0
		in_row(0, 0, 0, 0, 6, BEQ, 0, 0, 0, 0);
		out_row(9, 1, tb_jmp, CORR_CNI, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 6, BNE, 1, 0, 0, 0);
		out_row(7, 0, 0, CORR_CNI, tb_br, 1, 0);
		in_row(0, 0, 0, 0, 6, BLTU, 0, 0, 0, 0);
		out_row(7, 0, 0, CORR_NONE, tb_br, 1, 0);
		////////////////////////////////////////////////////////////////////
		// fifo replacement in set 6
		////////////////////////////////////////////////////////////////////
		in_row(10'h16, tf[0], 0, 1, 0, 0, 0, 0, 0, 0);
		out_row(8, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(10'h26, tf[1], 0, 1, 0, 0, 0, 0, 0, 0);
		out_row(9, 1, tb_jmp, CORR_NONE, 0, 0, 0);
		in_row(10'h36, tf[2], 0, 1, 0, 0, 0, 0, 0, 0);
		out_row(tb_jmp, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(10'h46, tf[3], 0, 1, 0, 0, 0, 0, 0, 0);
		out_row(tb_jmp + 1, 0, 0, CORR_NONE, 0, 0, 0);
		// oldest entry at 6 is gone
		in_row(0, 0, 0, 0, 6, BEQ, 0, 0, 0, 0);
		out_row(tb_jmp + 2, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 10'h16, BEQ, 0, 0, 0, 0);
		out_row(tb_jmp + 3, 0, 0, CORR_NONE, tf[0], 0, 0);
		in_row(0, 0, 0, 0, 10'h26, BEQ, 0, 0, 0, 0);
		out_row(tb_jmp + 4, 0, 0, CORR_NONE, tf[1], 0, 0);
		in_row(0, 0, 0, 0, 10'h36, BEQ, 0, 0, 0, 0);
		out_row(tb_jmp + 5, 0, 0, CORR_NONE, tf[2], 0, 0);
		in_row(0, 0, 0, 0, 10'h46, BEQ, 0, 0, 0, 0);
		out_row(tb_jmp + 6, 0, 0, CORR_NONE, tf[3], 0, 0);
		////////////////////////////////////////////////////////////////////
		// interrupt mode keeps the jump at 9 apart
		////////////////////////////////////////////////////////////////////
		in_row(0, 0, 0, 0, 9, BEQ, 0, 0, 1, 0);
		out_row(tb_jmp + 7, 0, 0, CORR_NONE, 0, 0, 0);
		in_row(0, 0, 0, 0, 9, BEQ, 1, 0, 0, 0);
		out_row(tb_jmp + 8, 0, 0, CORR_NONE, tb_jmp, 0, 0);
	endtask

	task automatic apply_row(input row_t r);
		id_pc = r.id_pc;
		id_target = r.id_target;
		id_is_jump = r.id_is_jump;
		id_is_btype = r.id_is_btype;
		exe_pc = r.exe_pc;
		exe_btype = r.exe_btype;
		exe_z = r.exe_z;
		exe_less = r.exe_less;
		isr_running = r.isr_running;
		stall = r.stall;
	endtask

	task automatic check_row(input row_t r);
		check_value("if_pc", 32'(if_pc), 32'(r.x_if_pc));
		check_value("if_prediction", 32'(if_prediction), 32'(r.x_pred));
		check_value("if_pbt", 32'(if_pbt), 32'(r.x_pbt));
		check_value("exe_correction", 32'(exe_correction), 32'(r.x_corr));
		check_value("exe_pbt", 32'(exe_pbt), 32'(r.x_exe_pbt));
		// next sequential instruction after the execute pc
		check_value("exe_cni", 32'(exe_cni), 32'(PC_W'(r.exe_pc + 1'b1)));
		check_value("flush", 32'(flush), 32'(r.x_flush));
		check_value("id_jump_in_bht", 32'(id_jump_in_bht), 32'(r.x_jib));
	endtask

	initial begin
		int unsigned seed_val;
		int wait_cnt;
		seed_val = $urandom(28054);
		nrst = 1'b0;
		en = 1'b1;
		stall = 1'b0;
		isr_running = 1'b0;
		id_pc = '0;
		id_target = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = '0;
		exe_btype = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		tb_br = random_target();
		tb_jmp = random_target();
		for (int i = 0; i < 4; i++) begin
			tf[i] = random_target();
		end
		build_rows();

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		nrst = 1'b1;

		// fetch pc must come out of reset at 0
		wait_cnt = 0;
		while (if_pc !== '0 && wait_cnt < 10) begin
			@(negedge CLK);
			wait_cnt++;
		end
		if (if_pc !== '0) begin
			$display("fetch pc did not come out of reset at zero");
			$display("Something failed");
			$fatal(1, "reset timeout");
		end

		// inputs change at the falling edge, outputs checked just before rising
		for (int r = 0; r < n_rows; r++) begin
			cur_row = r;
			apply_row(rows[r]);
			#4;
			check_row(rows[r]);
			@(negedge CLK);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== verilog/bht_pkg.sv ====
package bht_pkg;

	//////////////////////////////////////////////////////////////////////
	// program counter and table geometry
	//////////////////////////////////////////////////////////////////////

	// word address width of the core
	localparam int PC_W = 10;

	// set index comes from the lowest pc bits
	localparam int SET_W = 4;
	// way index inside one set
	localparam int WAY_W = 2;

	localparam int NUM_SETS = 1 << SET_W;
	localparam int NUM_WAYS = 1 << WAY_W;
	localparam int NUM_ENTRIES = NUM_SETS * NUM_WAYS;

	// tag is {isr mode, upper pc bits}
	localparam int TAG_W = 1 + PC_W - SET_W;
	// 2-bit saturating counter
	localparam int CNT_W = 2;

	//////////////////////////////////////////////////////////////////////
	// entry layout, msb first
	// valid | tag | target | counter
	//////////////////////////////////////////////////////////////////////

	localparam int ENTRY_W = 1 + TAG_W + PC_W + CNT_W;

	localparam int CNT_LSB = 0;
	localparam int TGT_LSB = CNT_LSB + CNT_W;
	localparam int TAG_LSB = TGT_LSB + PC_W;
	localparam int VALID_BIT = TAG_LSB + TAG_W;

endpackage

// ==== verilog/bht_table.sv ====
`timescale 1ns/100ps

module bht_table (
	input  logic                         CLK,
	input  logic                         nrst,
	input  logic                         en,
	input  logic                         stall,
	input  logic                         isr_running,
	input  logic [bht_pkg::PC_W-1:0]     if_pc,
	input  logic [bht_pkg::PC_W-1:0]     id_pc,
	input  logic [bht_pkg::PC_W-1:0]     id_target,
	input  logic                         id_is_jump,
	input  logic                         id_is_btype,
	input  logic [bht_pkg::PC_W-1:0]     exe_pc,
	input  logic [branch_pkg::BTYPE_W-1:0] exe_btype,
	input  logic                         exe_taken,
	output logic                         if_prediction,
	output logic [bht_pkg::PC_W-1:0]     if_pbt,
	output logic                         id_hit,
	output logic                         exe_hit_cnt_msb,
	output logic [bht_pkg::PC_W-1:0]     exe_pbt
);
	import bht_pkg::*;
	import branch_pkg::*;

	// entry storage, index is {set, way}
	logic [ENTRY_W-1:0] bht_mem [NUM_ENTRIES];
	// per set fifo pointer, names the next way to replace
	logic [WAY_W-1:0] fifo_ptr [NUM_SETS];

	logic [SET_W-1:0] if_set, id_set, exe_set;
	logic [TAG_W-1:0] if_tag, id_tag, exe_tag;
	logic [NUM_WAYS-1:0][ENTRY_W-1:0] if_ways, id_ways, exe_ways;
	// {hit, way} per lookup
	logic [WAY_W:0] if_sel, id_sel, exe_sel;
	logic [ENTRY_W-1:0] if_entry, exe_entry;
	logic exe_hit;
	logic [WAY_W-1:0] exe_way;

	logic ins_req, upd_req;
	logic [CNT_W-1:0] ins_cnt, exe_cnt, exe_cnt_next;
	logic [ENTRY_W-1:0] ins_entry;

	// search one set for a valid entry with matching tag
	// lowest matching way wins, returns {hit, way}
	function automatic logic [WAY_W:0] find_way(
		input logic [NUM_WAYS-1:0][ENTRY_W-1:0] ways,
		input logic [TAG_W-1:0]                 tag
	);
		logic [WAY_W:0] res;
		res = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (ways[w][VALID_BIT] && (ways[w][TAG_LSB +: TAG_W] == tag)) begin
				res = {1'b1, WAY_W'(w)};
			end
		end
		return res;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// lookups, fetch / decode / execute
	//////////////////////////////////////////////////////////////////////

	assign if_set = if_pc[SET_W-1:0];
	assign id_set = id_pc[SET_W-1:0];
	assign exe_set = exe_pc[SET_W-1:0];

	// isr mode bit keeps handler branches apart from normal code
	assign if_tag = {isr_running, if_pc[PC_W-1:SET_W]};
	assign id_tag = {isr_running, id_pc[PC_W-1:SET_W]};
	assign exe_tag = {isr_running, exe_pc[PC_W-1:SET_W]};

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if_ways[w] = bht_mem[{if_set, WAY_W'(w)}];
			id_ways[w] = bht_mem[{id_set, WAY_W'(w)}];
			exe_ways[w] = bht_mem[{exe_set, WAY_W'(w)}];
		end
	end

	assign if_sel = find_way(if_ways, if_tag);
	assign id_sel = find_way(id_ways, id_tag);
	assign exe_sel = find_way(exe_ways, exe_tag);

	// a miss reads as all zero, so not taken and target 0
	assign if_entry = if_sel[WAY_W] ? if_ways[if_sel[WAY_W-1:0]] : '0;
	assign exe_hit = exe_sel[WAY_W];
	assign exe_way = exe_sel[WAY_W-1:0];
	assign exe_entry = exe_hit ? exe_ways[exe_way] : '0;

	assign if_prediction = if_entry[CNT_LSB + CNT_W - 1];
	assign if_pbt = if_entry[TGT_LSB +: PC_W];
	assign id_hit = id_sel[WAY_W];
	assign exe_hit_cnt_msb = exe_entry[CNT_LSB + CNT_W - 1];
	assign exe_pbt = exe_entry[TGT_LSB +: PC_W];

	//////////////////////////////////////////////////////////////////////
	// insertion and counter training
	//////////////////////////////////////////////////////////////////////

	// new branch or jump at decode, not yet in the table
	assign ins_req = (id_is_btype || id_is_jump) && !id_hit;
	// resolved branch that is tracked here
	assign upd_req = (|exe_btype) && exe_hit;

	assign ins_cnt = id_is_jump ? CNT_W'(CNT_JUMP_INIT) : CNT_W'(CNT_BRANCH_INIT);
	assign exe_cnt = exe_entry[CNT_LSB +: CNT_W];

	always_comb begin
		ins_entry = '0;
		ins_entry[VALID_BIT] = 1'b1;
		ins_entry[TAG_LSB +: TAG_W] = id_tag;
		ins_entry[TGT_LSB +: PC_W] = id_target;
		ins_entry[CNT_LSB +: CNT_W] = ins_cnt;
	end

	// step one toward the outcome, saturate at both ends
	always_comb begin
		exe_cnt_next = exe_cnt;
		if (exe_taken) begin
			if (exe_cnt != CNT_W'(CNT_MAX)) begin
				exe_cnt_next = exe_cnt + 1'b1;
			end
		end else if (exe_cnt != '0) begin
			exe_cnt_next = exe_cnt - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				bht_mem[i] <= '0;
			end
			for (int s = 0; s < NUM_SETS; s++) begin
				fifo_ptr[s] <= '0;
			end
		end else if (en && !stall) begin
			// decode insertion has priority over execute update
			if (ins_req) begin
				bht_mem[{id_set, fifo_ptr[id_set]}] <= ins_entry;
				fifo_ptr[id_set] <= fifo_ptr[id_set] + 1'b1;
			end else if (upd_req) begin
				bht_mem[{exe_set, exe_way}][CNT_LSB +: CNT_W] <= exe_cnt_next;
			end
		end
	end

endmodule

// ==== verilog/branch_pkg.sv ====
package branch_pkg;

	//////////////////////////////////////////////////////////////////////
	// one-hot branch type from decode, bit positions
	//////////////////////////////////////////////////////////////////////

	localparam int BTYPE_W = 6;
	localparam int BT_BEQ = 5;
	localparam int BT_BNE = 4;
	localparam int BT_BLT = 3;
	localparam int BT_BGE = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;

	//////////////////////////////////////////////////////////////////////
	// execute correction codes for next pc selection
	//////////////////////////////////////////////////////////////////////

	localparam int CORR_W = 2;
	// code 1 also means no correction
	localparam logic [CORR_W-1:0] CORR_NONE = 2'd0;
	// redirect to correct next instruction
	localparam logic [CORR_W-1:0] CORR_CNI = 2'd2;
	// redirect to predicted branch target
	localparam logic [CORR_W-1:0] CORR_PBT = 2'd3;

	// counter start values, weakly not taken and strongly taken
	localparam int CNT_BRANCH_INIT = 1;
	localparam int CNT_JUMP_INIT = 3;
	localparam int CNT_MAX = 3;

endpackage

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor (
	input  logic                           CLK,
	input  logic                           nrst,
	input  logic                           en,
	input  logic                           stall,
	input  logic                           isr_running,
	input  logic [bht_pkg::PC_W-1:0]       id_pc,
	input  logic [bht_pkg::PC_W-1:0]       id_target,
	input  logic                           id_is_jump,
	input  logic                           id_is_btype,
	input  logic [bht_pkg::PC_W-1:0]       exe_pc,
	input  logic [branch_pkg::BTYPE_W-1:0] exe_btype,
	input  logic                           exe_z,
	input  logic                           exe_less,
	output logic [bht_pkg::PC_W-1:0]       if_pc,
	output logic                           if_prediction,
	output logic [bht_pkg::PC_W-1:0]       if_pbt,
	output logic [branch_pkg::CORR_W-1:0]  exe_correction,
	output logic [bht_pkg::PC_W-1:0]       exe_pbt,
	output logic [bht_pkg::PC_W-1:0]       exe_cni,
	output logic                           flush,
	output logic                           id_jump_in_bht
);

	// table to resolver
	logic id_hit;
	logic exe_hit_cnt_msb;
	// resolver back to table for training
	logic exe_taken;

	// history table with three lookup ports
	bht_table u_bht_table (
		.CLK             (CLK),
		.nrst            (nrst),
		.en              (en),
		.stall           (stall),
		.isr_running     (isr_running),
		.if_pc           (if_pc),
		.id_pc           (id_pc),
		.id_target       (id_target),
		.id_is_jump      (id_is_jump),
		.id_is_btype     (id_is_btype),
		.exe_pc          (exe_pc),
		.exe_btype       (exe_btype),
		.exe_taken       (exe_taken),
		.if_prediction   (if_prediction),
		.if_pbt          (if_pbt),
		.id_hit          (id_hit),
		.exe_hit_cnt_msb (exe_hit_cnt_msb),
		.exe_pbt         (exe_pbt)
	);

	// execute stage check and flush
	branch_resolver u_branch_resolver (
		.CLK             (CLK),
		.nrst            (nrst),
		.en              (en),
		.exe_pc          (exe_pc),
		.exe_btype       (exe_btype),
		.exe_z           (exe_z),
		.exe_less        (exe_less),
		.exe_hit_cnt_msb (exe_hit_cnt_msb),
		.id_is_jump      (id_is_jump),
		.id_hit          (id_hit),
		.exe_taken       (exe_taken),
		.exe_correction  (exe_correction),
		.exe_cni         (exe_cni),
		.flush           (flush),
		.id_jump_in_bht  (id_jump_in_bht)
	);

	// fetch address register
	fetch_pc_gen u_fetch_pc_gen (
		.CLK            (CLK),
		.nrst           (nrst),
		.en             (en),
		.stall          (stall),
		.if_prediction  (if_prediction),
		.if_pbt         (if_pbt),
		.exe_correction (exe_correction),
		.exe_pbt        (exe_pbt),
		.exe_cni        (exe_cni),
		.if_pc          (if_pc)
	);

endmodule

// ==== verilog/branch_resolver.sv ====
`timescale 1ns/100ps

module branch_resolver (
	input  logic                           CLK,
	input  logic                           nrst,
	input  logic                           en,
	input  logic [bht_pkg::PC_W-1:0]       exe_pc,
	input  logic [branch_pkg::BTYPE_W-1:0] exe_btype,
	input  logic                           exe_z,
	input  logic                           exe_less,
	input  logic                           exe_hit_cnt_msb,
	input  logic                           id_is_jump,
	input  logic                           id_hit,
	output logic                           exe_taken,
	output logic [branch_pkg::CORR_W-1:0]  exe_correction,
	output logic [bht_pkg::PC_W-1:0]       exe_cni,
	output logic                           flush,
	output logic                           id_jump_in_bht
);
	import branch_pkg::*;

	logic is_branch;
	logic mispredict;
	// flush request for the next enabled cycle
	logic flush_next;
	logic flush_d;

	//////////////////////////////////////////////////////////////////////
	// branch condition from alu flags
	//////////////////////////////////////////////////////////////////////

	// signed and unsigned compares share the less flag
	assign exe_taken = (exe_btype[BT_BEQ] && exe_z)
		|| (exe_btype[BT_BNE] && !exe_z)
		|| ((exe_btype[BT_BLT] || exe_btype[BT_BLTU]) && exe_less)
		|| ((exe_btype[BT_BGE] || exe_btype[BT_BGEU]) && !exe_less);

	assign is_branch = |exe_btype;
	// counter msb was the prediction made at fetch
	assign mispredict = is_branch && (exe_hit_cnt_msb != exe_taken);

	always_comb begin
		if (!mispredict) begin
			exe_correction = CORR_NONE;
		end else if (exe_taken) begin
			exe_correction = CORR_PBT;
		end else begin
			exe_correction = CORR_CNI;
		end
	end

	assign exe_cni = exe_pc + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// flush control
	//////////////////////////////////////////////////////////////////////

	// mispredict flushes now and next cycle, new jump only next cycle
	assign flush = flush_d || mispredict;
	assign flush_next = mispredict || (id_is_jump && !id_hit);

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			flush_d <= 1'b0;
		end else if (en) begin
			flush_d <= flush_next;
		end
	end

	// jump already known, fetch will follow the stored target
	assign id_jump_in_bht = id_is_jump && id_hit;

endmodule

// ==== verilog/fetch_pc_gen.sv ====
`timescale 1ns/100ps

module fetch_pc_gen (
	input  logic                          CLK,
	input  logic                          nrst,
	input  logic                          en,
	input  logic                          stall,
	input  logic                          if_prediction,
	input  logic [bht_pkg::PC_W-1:0]      if_pbt,
	input  logic [branch_pkg::CORR_W-1:0] exe_correction,
	input  logic [bht_pkg::PC_W-1:0]      exe_pbt,
	input  logic [bht_pkg::PC_W-1:0]      exe_cni,
	output logic [bht_pkg::PC_W-1:0]      if_pc
);
	import branch_pkg::*;

	logic [bht_pkg::PC_W-1:0] pc_next;

	//////////////////////////////////////////////////////////////////////
	// next fetch address
	//////////////////////////////////////////////////////////////////////

	// execute correction beats the fetch prediction
	always_comb begin
		case (exe_correction)
			CORR_CNI: begin
				pc_next = exe_cni;
			end
			CORR_PBT: begin
				pc_next = exe_pbt;
			end
			default: begin
				// prediction is only set on a fetch hit
				if (if_prediction) begin
					pc_next = if_pbt;
				end else begin
					pc_next = if_pc + 1'b1;
				end
			end
		endcase
	end

	// stall holds the fetch pc
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			if_pc <= '0;
		end else if (en && !stall) begin
			if_pc <= pc_next;
		end
	end

endmodule
